//--- Makefile
TOP = tb_poker_table

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

obj_dir/V$(TOP): vlog.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f

lint:
	verilator --lint-only -Wall --timing --top-module poker_table_top -f vlog.f

clean:
	rm -rf obj_dir

//--- chip_display.sv
`timescale 1ns/100ps
`default_nettype none

module chip_display import poker_game_pkg::*, poker_disp_pkg::*; (
    input  chip_t      pot,
    input  chip_t      stack_one,
    input  chip_t      stack_two,
    output chip_disp_t disp
);

    digit_t pot_tens;
    digit_t pot_units;
    digit_t one_tens;
    digit_t one_units;
    digit_t two_tens;
    digit_t two_units;

    // tens can reach 12, the encoder blanks anything above nine
    function automatic digit_t tens_of(chip_t v);
        return digit_t'(v / chip_t'(10));
    endfunction

    function automatic digit_t units_of(chip_t v);
        return digit_t'(v % chip_t'(10));
    endfunction

    assign pot_tens  = tens_of(pot);
    assign pot_units = units_of(pot);
    assign one_tens  = tens_of(stack_one);
    assign one_units = units_of(stack_one);
    assign two_tens  = tens_of(stack_two);
    assign two_units = units_of(stack_two);

    // pot display is common cathode
    seg_encoder #(.ACTIVE_LOW(1'b0)) u_pot_tens  (.digit(pot_tens),  .seg(disp.pot_seg_tens));
    seg_encoder #(.ACTIVE_LOW(1'b0)) u_pot_units (.digit(pot_units), .seg(disp.pot_seg_units));

    seg_encoder #(.ACTIVE_LOW(1'b1)) u_one_tens  (.digit(one_tens),  .seg(disp.one_seg_tens));
    seg_encoder #(.ACTIVE_LOW(1'b1)) u_one_units (.digit(one_units), .seg(disp.one_seg_units));
    seg_encoder #(.ACTIVE_LOW(1'b1)) u_two_tens  (.digit(two_tens),  .seg(disp.two_seg_tens));
    seg_encoder #(.ACTIVE_LOW(1'b1)) u_two_units (.digit(two_units), .seg(disp.two_seg_units));

endmodule

`default_nettype wire

//--- chip_ledger.sv
`timescale 1ns/100ps
`default_nettype none

`include "poker_macros.svh"

module chip_ledger import poker_game_pkg::*; (
    input  logic        clk,
    input  logic        call_p,
    input  ledger_cmd_t cmd,
    output logic        bet_open,
    output chip_t       stack_one,
    output chip_t       stack_two,
    output chip_t       pot
);

    localparam chip_t raise_step  = chip_t'(`POKER_RAISE_STEP);
    localparam chip_t start_stack = chip_t'(`POKER_START_STACK);

    chip_t bet_q;
    chip_t stake_one_q;
    chip_t stake_two_q;

    chip_t stack_one_d;
    chip_t stack_two_d;
    chip_t pot_d;
    chip_t bet_d;
    chip_t stake_one_d;
    chip_t stake_two_d;
    chip_t stake_actor;
    chip_t owed;
    chip_t pay;

    assign stake_actor = (cmd.actor == player_one) ? stake_one_q : stake_two_q;
    assign owed        = bet_q - stake_actor;

    always_comb begin
        stack_one_d = stack_one;
        stack_two_d = stack_two;
        bet_d       = bet_q;
        stake_one_d = stake_one_q;
        stake_two_d = stake_two_q;

        case (cmd.op)
            ledger_raise:                      pay = owed + raise_step;
            ledger_call, ledger_call_showdown: pay = owed;
            default:                           pay = '0;
        endcase

        // actor pays into the pot first
        if (cmd.actor == player_one) begin
            stack_one_d = stack_one - pay;
        end else begin
            stack_two_d = stack_two - pay;
        end
        pot_d = pot + pay;

        case (cmd.op)
            ledger_raise: begin
                bet_d = bet_q + raise_step;
                if (cmd.actor == player_one) begin
                    stake_one_d = bet_q + raise_step;
                end else begin
                    stake_two_d = bet_q + raise_step;
                end
            end
            ledger_call, ledger_close_street: begin
                bet_d       = '0;
                stake_one_d = '0;
                stake_two_d = '0;
            end
            ledger_fold: begin
                if (cmd.actor == player_one) begin
                    stack_two_d = stack_two + pot_d;
                end else begin
                    stack_one_d = stack_one + pot_d;
                end
                pot_d       = '0;
                bet_d       = '0;
                stake_one_d = '0;
                stake_two_d = '0;
            end
            ledger_showdown, ledger_call_showdown: begin
                stack_one_d = stack_one_d + pot_d;   // no card logic, player one wins
                pot_d       = '0;
                bet_d       = '0;
                stake_one_d = '0;
                stake_two_d = '0;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge call_p) begin
        if (call_p) begin
            stack_one   <= start_stack;
            stack_two   <= start_stack;
            pot         <= '0;
            bet_q       <= '0;
            stake_one_q <= '0;
            stake_two_q <= '0;
        end else begin
            stack_one   <= stack_one_d;
            stack_two   <= stack_two_d;
            pot         <= pot_d;
            bet_q       <= bet_d;
            stake_one_q <= stake_one_d;
            stake_two_q <= stake_two_d;
        end
    end

    assign bet_open = (bet_q != '0);

endmodule

`default_nettype wire

//--- poker_disp_pkg.sv
`default_nettype none

`include "poker_macros.svh"

package poker_disp_pkg;

    typedef logic [3:0] digit_t;

    typedef logic [`POKER_SEG_W-1:0] seg_t;   // bit 0 is segment a

    typedef struct packed {
        seg_t pot_seg_tens;
        seg_t pot_seg_units;
        seg_t one_seg_tens;
        seg_t one_seg_units;
        seg_t two_seg_tens;
        seg_t two_seg_units;
    } chip_disp_t;

endpackage

`default_nettype wire

//--- poker_game_pkg.sv
`default_nettype none

`include "poker_macros.svh"

package poker_game_pkg;

    typedef logic [`POKER_CHIP_W-1:0] chip_t;

    typedef enum logic [0:0] {
        game_playing,
        game_cashout
    } game_state_e;

    typedef enum logic [1:0] {
        street_preflop,
        street_flop,
        street_turn,
        street_river
    } street_e;

    typedef enum logic [1:0] {
        act_none,
        act_fold,
        act_call,       // check when no bet is open
        act_raise
    } action_e;

    typedef enum logic [0:0] {
        player_one,
        player_two
    } player_e;

    typedef enum logic [2:0] {
        ledger_idle,
        ledger_fold,
        ledger_call,
        ledger_raise,
        ledger_close_street,
        ledger_showdown,
        ledger_call_showdown
    } ledger_op_e;

    typedef struct packed {
        ledger_op_e op;
        player_e    actor;
    } ledger_cmd_t;

    typedef struct packed {
        game_state_e state;
        street_e     street;
        player_e     turn;
    } table_status_t;

endpackage

`default_nettype wire

//--- poker_macros.svh
`ifndef POKER_MACROS_SVH
`define POKER_MACROS_SVH

// width of every chip quantity, arithmetic wraps at this width
`define POKER_CHIP_W 7

// each stack after reset
`define POKER_START_STACK 49

// fixed raise increment above the current bet
`define POKER_RAISE_STEP 5

// segment pattern width, bit 0 is segment a
`define POKER_SEG_W 7

`endif

//--- poker_table_top.sv
`timescale 1ns/100ps
`default_nettype none

module poker_table_top import poker_game_pkg::*, poker_disp_pkg::*; (
    input  logic          clk,
    input  logic          call_p,
    input  action_e       action,
    input  logic          cashout,
    output table_status_t status,
    output chip_t         stack_one,
    output chip_t         stack_two,
    output chip_t         pot,
    output chip_disp_t    disp
);

    ledger_cmd_t cmd;        // combinational, applied at the sampling edge
    logic        bet_open;

    table_ctrl u_table_ctrl (
        .clk      (clk),
        .call_p   (call_p),
        .action   (action),
        .cashout  (cashout),
        .bet_open (bet_open),
        .cmd      (cmd),
        .status   (status)
    );

    chip_ledger u_chip_ledger (
        .clk       (clk),
        .call_p    (call_p),
        .cmd       (cmd),
        .bet_open  (bet_open),
        .stack_one (stack_one),
        .stack_two (stack_two),
        .pot       (pot)
    );

    chip_display u_chip_display (
        .pot       (pot),
        .stack_one (stack_one),
        .stack_two (stack_two),
        .disp      (disp)
    );

endmodule

`default_nettype wire

//--- seg_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module seg_encoder import poker_disp_pkg::*; #(
    parameter bit ACTIVE_LOW = 1'b0
) (
    input  digit_t digit,
    output seg_t   seg
);

    seg_t pattern;   // active high, gfedcba

    always_comb begin
        case (digit)
            4'd0:    pattern = 7'h3f;
            4'd1:    pattern = 7'h06;
            4'd2:    pattern = 7'h5b;
            4'd3:    pattern = 7'h4f;
            4'd4:    pattern = 7'h66;
            4'd5:    pattern = 7'h6d;
            4'd6:    pattern = 7'h7d;
            4'd7:    pattern = 7'h07;
            4'd8:    pattern = 7'h7f;
            4'd9:    pattern = 7'h6f;
            default: pattern = '0;   // blank
        endcase
    end

    assign seg = ACTIVE_LOW ? ~pattern : pattern;

endmodule

`default_nettype wire

//--- table_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module table_ctrl import poker_game_pkg::*; (
    input  logic          clk,
    input  logic          call_p,
    input  action_e       action,
    input  logic          cashout,
    input  logic          bet_open,
    output ledger_cmd_t   cmd,
    output table_status_t status
);

    game_state_e state_q;
    game_state_e state_d;
    street_e     street_q;
    street_e     street_d;
    player_e     turn_q;
    player_e     turn_d;
    player_e     first_q;       // opens every street of this hand
    player_e     first_d;
    logic        close_street;
    logic        end_hand;
    logic        on_river;

    function automatic player_e other_player(player_e p);
        return (p == player_one) ? player_two : player_one;
    endfunction

    assign on_river = (street_q == street_river);

    always_comb begin
        state_d      = state_q;
        street_d     = street_q;
        turn_d       = turn_q;
        first_d      = first_q;
        close_street = 1'b0;
        end_hand     = 1'b0;
        cmd.op       = ledger_idle;
        cmd.actor    = turn_q;

        case (state_q)
            game_playing: begin
                if (cashout && street_q == street_preflop) begin
                    state_d = game_cashout;   // only between hands
                end
                case (action)
                    act_fold: begin
                        cmd.op   = ledger_fold;
                        end_hand = 1'b1;
                    end
                    act_raise: begin
                        cmd.op = ledger_raise;
                        turn_d = other_player(turn_q);
                    end
                    act_call: begin
                        if (bet_open) begin
                            cmd.op       = on_river ? ledger_call_showdown : ledger_call;
                            close_street = 1'b1;
                        end else if (turn_q == first_q) begin
                            turn_d = other_player(turn_q);   // opener checks
                        end else begin
                            cmd.op       = on_river ? ledger_showdown : ledger_close_street;
                            close_street = 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            game_cashout: begin
                if (!cashout) begin
                    state_d = game_playing;
                end
            end
        endcase

        if (close_street) begin
            if (on_river) begin
                end_hand = 1'b1;
            end else begin
                street_d = street_e'(street_q + 2'd1);
                turn_d   = first_q;
            end
        end

        // next hand is opened by the other player
        if (end_hand) begin
            street_d = street_preflop;
            first_d  = other_player(first_q);
            turn_d   = other_player(first_q);
        end
    end

    always_ff @(posedge clk or posedge call_p) begin
        if (call_p) begin
            state_q  <= game_playing;
            street_q <= street_preflop;
            turn_q   <= player_one;
            first_q  <= player_one;
        end else begin
            state_q  <= state_d;
            street_q <= street_d;
            turn_q   <= turn_d;
            first_q  <= first_d;
        end
    end

    assign status = '{state: state_q, street: street_q, turn: turn_q};

endmodule

`default_nettype wire

//--- tb_poker_model.svh
`ifndef TB_POKER_MODEL_SVH
`define TB_POKER_MODEL_SVH

`include "poker_macros.svh"

typedef struct packed {
    table_status_t st;
    player_e       first;          // opens every street of the hand
    chip_t         stack_one;
    chip_t         stack_two;
    chip_t         pot;
    chip_t         bet;
    chip_t         stake_one;
    chip_t         stake_two;
} model_t;

localparam chip_t model_raise = chip_t'(`POKER_RAISE_STEP);
localparam chip_t model_stack = chip_t'(`POKER_START_STACK);

function automatic player_e opponent_of(player_e p);
    return (p == player_one) ? player_two : player_one;
endfunction

function automatic street_e next_street(street_e s);
    case (s)
        street_preflop: return street_flop;
        street_flop:    return street_turn;
        default:        return street_river;
    endcase
endfunction

function automatic model_t reset_state();
    model_t m;
    m           = '0;   // playing, preflop, player one to act and open
    m.stack_one = model_stack;
    m.stack_two = model_stack;
    return m;
endfunction

// one sampled action, chip sums wrap at 7 bits
function automatic model_t apply_action(model_t m, action_e a, logic co);
    model_t n;
    chip_t  owed;
    chip_t  pay;
    logic   closing;
    logic   folded;
    logic   river;
    n       = m;
    pay     = '0;
    closing = 1'b0;
    folded  = 1'b0;
    river   = (m.st.street == street_river);
    owed    = m.bet - ((m.st.turn == player_one) ? m.stake_one : m.stake_two);
    if (m.st.state == game_cashout) begin
        if (!co) begin
            n.st.state = game_playing;
        end
    end else begin
        if (co && m.st.street == street_preflop) begin
            n.st.state = game_cashout;
        end
        case (a)
            act_raise: begin
                pay   = owed + model_raise;
                n.bet = m.bet + model_raise;
                if (m.st.turn == player_one) begin
                    n.stake_one = n.bet;
                end else begin
                    n.stake_two = n.bet;
                end
                n.st.turn = opponent_of(m.st.turn);
            end
            act_call: begin
                if (m.bet != '0) begin
                    pay     = owed;
                    closing = 1'b1;
                end else if (m.st.turn == m.first) begin
                    n.st.turn = opponent_of(m.st.turn);
                end else begin
                    closing = 1'b1;
                end
            end
            act_fold: folded = 1'b1;
            default: begin
            end
        endcase
        if (m.st.turn == player_one) begin
            n.stack_one = m.stack_one - pay;
        end else begin
            n.stack_two = m.stack_two - pay;
        end
        n.pot = m.pot + pay;
        if (closing || folded) begin
            n.bet       = '0;
            n.stake_one = '0;
            n.stake_two = '0;
        end
        if (folded && m.st.turn == player_one) begin
            n.stack_two = n.stack_two + n.pot;
        end else if (folded) begin
            n.stack_one = n.stack_one + n.pot;
        end
        if (closing && river) begin
            n.stack_one = n.stack_one + n.pot;   // showdown always to player one
        end else if (closing) begin
            n.st.street = next_street(m.st.street);
            n.st.turn   = m.first;
        end
        if (folded || (closing && river)) begin
            n.pot       = '0;
            n.st.street = street_preflop;
            n.first     = opponent_of(m.first);
            n.st.turn   = opponent_of(m.first);
        end
    end
    return n;
endfunction

function automatic seg_t segments_for(int value, bit low);
    seg_t p;
    case (value)
        0: p = 7'b011_1111;
        1: p = 7'b000_0110;
        2: p = 7'b101_1011;
        3: p = 7'b100_1111;
        4: p = 7'b110_0110;
        5: p = 7'b110_1101;
        6: p = 7'b111_1101;
        7: p = 7'b000_0111;
        8: p = 7'b111_1111;
        9: p = 7'b110_1111;
        default: p = '0;
    endcase
    return low ? ~p : p;
endfunction

function automatic chip_disp_t expected_disp(model_t e);
    chip_disp_t d;
    d.pot_seg_tens  = segments_for(int'(e.pot) / 10, 1'b0);
    d.pot_seg_units = segments_for(int'(e.pot) % 10, 1'b0);
    d.one_seg_tens  = segments_for(int'(e.stack_one) / 10, 1'b1);
    d.one_seg_units = segments_for(int'(e.stack_one) % 10, 1'b1);
    d.two_seg_tens  = segments_for(int'(e.stack_two) / 10, 1'b1);
    d.two_seg_units = segments_for(int'(e.stack_two) % 10, 1'b1);
    return d;
endfunction

`endif

//--- tb_poker_table.sv
`timescale 1ns/100ps
`default_nettype none

`include "poker_macros.svh"

module tb_poker_table import poker_game_pkg::*, poker_disp_pkg::*; ();

    localparam int reset_cycles   = 8;
    localparam int directed_steps = 70;   // upper bound on the directed hands
    localparam int random_actions = 400;
    localparam int max_cycles     = reset_cycles + directed_steps + random_actions + 40;

    logic          clk = 1'b0;
    logic          call_p;
    action_e       action;
    logic          cashout;
    table_status_t status;
    chip_t         stack_one;
    chip_t         stack_two;
    chip_t         pot;
    chip_disp_t    disp;
    logic          reset_done = 1'b0;
    int            checks_done = 0;
    int            seed;

    `include "tb_poker_model.svh"

    poker_table_top dut0 (
        .clk       (clk),
        .call_p    (call_p),
        .action    (action),
        .cashout   (cashout),
        .status    (status),
        .stack_one (stack_one),
        .stack_two (stack_two),
        .pot       (pot),
        .disp      (disp)
    );

    always #10 clk = ~clk;

    task automatic report_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic fail_value(string name, logic [63:0] want, logic [63:0] got);
        $display("FAIL %s expected %0h actual %0h at %0t", name, want, got, $time);
        report_failure();
    endtask

    task automatic compare_outputs(model_t e);
        chip_disp_t want_disp;
        want_disp = expected_disp(e);
        assert (status == e.st)
            else fail_value("status", 64'(e.st), 64'(status));
        assert (stack_one == e.stack_one)
            else fail_value("stack_one", 64'(e.stack_one), 64'(stack_one));
        assert (stack_two == e.stack_two)
            else fail_value("stack_two", 64'(e.stack_two), 64'(stack_two));
        assert (pot == e.pot)
            else fail_value("pot", 64'(e.pot), 64'(pot));
        assert (disp == want_disp)
            else fail_value("disp", 64'(want_disp), 64'(disp));
    endtask

    task automatic drive_action(action_e a, logic co);
        @(posedge clk);
        #2;
        action  = a;
        cashout = co;
    endtask

    // both players check once per street
    task automatic pass_streets(int streets);
        repeat (streets) begin
            drive_action(act_call, 1'b0);
            drive_action(act_call, 1'b0);
        end
    endtask

    initial begin : stimulus
        logic [31:0] r;
        logic        co_level;
        seed     = 32'h7097_1d9d;
        co_level = 1'b0;
        call_p   = 1'b1;
        action   = act_none;
        cashout  = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        call_p     = 1'b0;
        reset_done = 1'b1;
        drive_action(act_raise, 1'b0);   // raise, re-raise, call closes preflop
        drive_action(act_raise, 1'b0);
        drive_action(act_call, 1'b0);
        pass_streets(3);                 // check-through showdown
        pass_streets(3);                 // player two opens this hand
        drive_action(act_raise, 1'b0);
        drive_action(act_call, 1'b0);    // call on the river
        drive_action(act_raise, 1'b0);
        drive_action(act_fold, 1'b0);    // fold preflop
        pass_streets(1);
        drive_action(act_raise, 1'b0);
        drive_action(act_fold, 1'b0);    // fold on the flop
        pass_streets(2);
        drive_action(act_fold, 1'b0);    // fold on the turn with no bet
        pass_streets(3);
        drive_action(act_raise, 1'b0);
        drive_action(act_raise, 1'b0);
        drive_action(act_fold, 1'b0);    // fold on the river
        pass_streets(1);
        drive_action(act_raise, 1'b1);   // cashout held from the flop on
        repeat (5) drive_action(act_call, 1'b1);
        drive_action(act_none, 1'b1);
        drive_action(act_raise, 1'b1);
        drive_action(act_fold, 1'b1);
        drive_action(act_call, 1'b1);
        drive_action(act_none, 1'b0);
        drive_action(act_raise, 1'b0);
        drive_action(act_call, 1'b0);
        for (int i = 0; i < random_actions; i++) begin
            r = $random(seed);
            if (r[9:5] == 5'd0) begin
                co_level = ~co_level;
            end
            drive_action(action_e'(r[1:0]), co_level);
        end
        drive_action(act_none, 1'b0);
        drive_action(act_none, 1'b0);
        @(negedge clk);
        #1;
        if (checks_done > random_actions) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("comparison process ran only %0d checks", checks_done);
            report_failure();
        end
    end

    initial begin : comparator
        model_t  exp_m;
        action_e a_smp;
        logic    co_smp;
        exp_m = reset_state();
        wait (reset_done);
        forever begin
            @(posedge clk);
            a_smp  = action;   // stable since 2 ns after the previous edge
            co_smp = cashout;
            @(negedge clk);
            exp_m = apply_action(exp_m, a_smp, co_smp);
            compare_outputs(exp_m);
            checks_done = checks_done + 1;
        end
    end

    initial begin : watchdog
        repeat (max_cycles) @(posedge clk);
        $display("run timed out after %0d clock cycles", max_cycles);
        report_failure();
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
poker_game_pkg.sv
poker_disp_pkg.sv
seg_encoder.sv
chip_display.sv
chip_ledger.sv
table_ctrl.sv
poker_table_top.sv
tb_poker_table.sv
